// ==== compile.f ====
hdl/ifu_err_pkg.sv
hdl/err_source_stage.sv
hdl/err_addr_file.sv
hdl/asi_read_ctl.sv
hdl/asi_read_data.sv
hdl/ifu_err_buffer.sv
sim/ifu_err_asserts.sv
sim/ifu_err_checker.sv
sim/ifu_err_buffer_tb.sv

// ==== Bender.yml ====
package:
  name: ifu_err_buffer

sources:
  - hdl/ifu_err_pkg.sv
  - hdl/err_source_stage.sv
  - hdl/err_addr_file.sv
  - hdl/asi_read_ctl.sv
  - hdl/asi_read_data.sv
  - hdl/ifu_err_buffer.sv
  - target: simulation
    files:
      - sim/ifu_err_asserts.sv
      - sim/ifu_err_checker.sv
      - sim/ifu_err_buffer_tb.sv

// ==== sim/ifu_err_buffer_tb.sv ====
`timescale 1ns/1ps
// ifu error buffer testbench driving random captures and asi reads against a reference model
module ifu_err_buffer_tb;
   import ifu_err_pkg::*;

   localparam int NUM_THREADS  = 4;
   localparam int RESET_CYCLES = 8;
   localparam int NUM_OPS      = 300;
   // longest op is a read with the longest hold
   localparam int OP_MAX       = 10;
   // random ops plus the directed reads after reset
   localparam int CYCLE_LIMIT  = RESET_CYCLES + (NUM_OPS + 16) * OP_MAX;

   logic                       rclk = 1'b0;
   logic                       rst_n;
   logic [7:0]                 irf_reg;
   logic [7:0]                 irf_synd;
   logic [5:0]                 frf_reg;
   logic [13:0]                frf_synd;
   logic [5:0]                 itlb_index;
   logic [EADDR_W-1:0]         lsu_err_addr;
   logic [PC_W-1:0]            fetch_pc;
   logic [PA_W-PA_LO_W-1:0]    itlb_paddr;
   logic [ASI_W-1:0]           asi_wdata;
   logic                       imask_ld;
   err_src_e [NUM_THREADS-1:0] capture_sel;
   logic                       asi_req;
   asi_rd_e                    asi_rd_sel;
   logic [1:0]                 asi_rd_thread;
   logic                       asi_ack;
   logic [ASI_W-1:0]           asi_rdata;
   logic [IMASK_W-1:0]         imask;
   // expected values handed to the checker
   logic [ASI_W-1:0]           exp_rdata;
   logic [IMASK_W-1:0]         exp_imask;
   int unsigned                reads_checked;
   int unsigned                data_errs;
   int unsigned                hs_errs;
   int unsigned                assert_fails;

   // ----------------------------------------------------------
   // reference model state
   // ----------------------------------------------------------
   logic [EADDR_W-1:0]         err_m [NUM_THREADS];
   logic [IMASK_W-1:0]         mask_m = '0;
   // input history one edge back
   logic [7:0]                 irf_reg_h = '0;
   logic [7:0]                 irf_synd_h = '0;
   logic [5:0]                 itlb_h = '0;
   logic [EADDR_W-1:0]         lsu_h = '0;
   logic [PA_W-PA_LO_W-1:0]    paddr_h = '0;
   // pc one and two edges back
   logic [PC_W-1:0]            pc_h1 = '0;
   logic [PC_W-1:0]            pc_h2 = '0;
   logic [31:0]                rng = 32'ha279;
   bit                         captures_on = 1'b0;
   int unsigned                cycle_cnt = 0;

   always #50 rclk = ~rclk;

   ifu_err_buffer #(
      .NUM_THREADS (NUM_THREADS)
   ) i_ifu_err_buffer (
      .rclk          (rclk),
      .rst_n         (rst_n),
      .irf_reg       (irf_reg),
      .irf_synd      (irf_synd),
      .frf_reg       (frf_reg),
      .frf_synd      (frf_synd),
      .itlb_index    (itlb_index),
      .lsu_err_addr  (lsu_err_addr),
      .fetch_pc      (fetch_pc),
      .itlb_paddr    (itlb_paddr),
      .asi_wdata     (asi_wdata),
      .imask_ld      (imask_ld),
      .capture_sel   (capture_sel),
      .asi_req       (asi_req),
      .asi_rd_sel    (asi_rd_sel),
      .asi_rd_thread (asi_rd_thread),
      .asi_ack       (asi_ack),
      .asi_rdata     (asi_rdata),
      .imask         (imask)
   );

   ifu_err_checker i_ifu_err_checker (
      .rclk          (rclk),
      .rst_n         (rst_n),
      .asi_req       (asi_req),
      .asi_ack       (asi_ack),
      .asi_rdata     (asi_rdata),
      .imask         (imask),
      .exp_rdata     (exp_rdata),
      .exp_imask     (exp_imask),
      .reads_checked (reads_checked),
      .data_errs     (data_errs),
      .hs_errs       (hs_errs)
   );

   // ----------------------------------------------------------
   // random numbers
   // ----------------------------------------------------------
   function automatic logic [31:0] xorshift32(input logic [31:0] s);
      logic [31:0] x;
      x = s;
      x = x ^ (x << 13);
      x = x ^ (x >> 17);
      x = x ^ (x << 5);
      return x;
   endfunction

   function automatic logic [63:0] rand64();
      logic [31:0] hi;
      rng = xorshift32(rng);
      hi  = rng;
      rng = xorshift32(rng);
      return {hi, rng};
   endfunction

   // ----------------------------------------------------------
   // reference functions
   // ----------------------------------------------------------
   // candidate word for a source from history before this edge
   function automatic logic [EADDR_W-1:0] expected_word(input err_src_e src);
      logic [EADDR_W-1:0] w;
      logic [7:0]         rn;
      w  = '0;
      rn = irf_reg_h;
      case (src)
         SRC_IRF: begin
            // bit 4 flips when bits 5 and 3 are both set
            if (rn[5] && rn[3]) rn[4] = ~rn[4];
            w[7:0]   = rn;
            w[19:12] = irf_synd_h;
         end
         SRC_FRF: begin
            w[5:0]   = frf_reg;
            w[18:12] = frf_synd[6:0];
            w[26:20] = frf_synd[13:7];
         end
         SRC_ITLB:   w[5:0] = itlb_h;
         SRC_LSU:    w = lsu_h;
         SRC_PC:     w = pc_h2[47:4];
         SRC_PADDR: begin
            // page offset from the older pc
            w[5:0]  = pc_h2[9:4];
            w[35:6] = paddr_h;
         end
         SRC_ASI_WR: w = asi_wdata[47:4];
         default:    w = '0;
      endcase
      return w;
   endfunction

   function automatic logic [ASI_W-1:0] read_word(input asi_rd_e sel, input logic [1:0] thr);
      logic [ASI_W-1:0] r;
      r = '0;
      if (sel == RD_IMASK) begin
         r[IMASK_W-1:0] = mask_m;
      end else begin
         r[47:4] = err_m[thr];
      end
      return r;
   endfunction

   // advance the model by one edge using the inputs sampled there
   function automatic void model_step();
      if (!rst_n) begin
         foreach (err_m[t]) err_m[t] = '0;
         mask_m     = '0;
         irf_reg_h  = '0;
         irf_synd_h = '0;
         itlb_h     = '0;
         lsu_h      = '0;
         paddr_h    = '0;
         pc_h1      = '0;
         pc_h2      = '0;
      end else begin
         for (int t = 0; t < NUM_THREADS; t++) begin
            if (capture_sel[t] != SRC_HOLD) err_m[t] = expected_word(capture_sel[t]);
         end
         if (imask_ld) mask_m = asi_wdata[IMASK_W-1:0];
         pc_h2      = pc_h1;
         pc_h1      = fetch_pc;
         irf_reg_h  = irf_reg;
         irf_synd_h = irf_synd;
         itlb_h     = itlb_index;
         lsu_h      = lsu_err_addr;
         paddr_h    = itlb_paddr;
      end
   endfunction

   // ----------------------------------------------------------
   // stimulus
   // ----------------------------------------------------------
   task automatic drive_sources();
      logic [63:0] r;
      r = rand64();
      irf_reg      <= r[7:0];
      irf_synd     <= r[15:8];
      frf_reg      <= r[21:16];
      frf_synd     <= r[35:22];
      itlb_index   <= r[41:36];
      r = rand64();
      lsu_err_addr <= r[EADDR_W-1:0];
      r = rand64();
      fetch_pc     <= r[PC_W-1:0];
      r = rand64();
      itlb_paddr   <= r[PA_W-PA_LO_W-1:0];
      asi_wdata    <= rand64();
      r = rand64();
      // about one thread in four captures per cycle
      for (int t = 0; t < NUM_THREADS; t++) begin
         if (captures_on && r[8*t +: 2] == 2'b00) begin
            capture_sel[t] <= err_src_e'(r[8*t+2 +: 3]);
         end else begin
            capture_sel[t] <= SRC_HOLD;
         end
      end
      imask_ld <= captures_on && (r[63:61] == 3'b000);
   endtask

   task automatic tick();
      @(posedge rclk);
      model_step();
      exp_imask <= mask_m;
      drive_sources();
   endtask

   task automatic do_read(input asi_rd_e sel, input logic [1:0] thr, input int hold);
      tick();
      asi_req       <= 1'b1;
      asi_rd_sel    <= sel;
      asi_rd_thread <= thr;
      // edge that samples the request
      tick();
      // read register loads on the next edge from this state
      exp_rdata <= read_word(sel, thr);
      while (!asi_ack) tick();
      repeat (hold) tick();
      asi_req <= 1'b0;
      while (asi_ack) tick();
   endtask

   initial begin
      logic [63:0] r;
      rst_n         <= 1'b0;
      irf_reg       <= '0;
      irf_synd      <= '0;
      frf_reg       <= '0;
      frf_synd      <= '0;
      itlb_index    <= '0;
      lsu_err_addr  <= '0;
      fetch_pc      <= '0;
      itlb_paddr    <= '0;
      asi_wdata     <= '0;
      imask_ld      <= 1'b0;
      for (int t = 0; t < NUM_THREADS; t++) capture_sel[t] <= SRC_HOLD;
      asi_req       <= 1'b0;
      asi_rd_sel    <= RD_ERR_ADDR;
      asi_rd_thread <= '0;
      exp_rdata     <= '0;
      exp_imask     <= '0;
      repeat (RESET_CYCLES) tick();
      rst_n <= 1'b1;
      // everything reads zero out of reset
      for (int t = 0; t < NUM_THREADS; t++) do_read(RD_ERR_ADDR, 2'(t), 0);
      do_read(RD_IMASK, 2'd0, 1);
      // one mask load and its read back
      tick();
      imask_ld  <= 1'b1;
      asi_wdata <= rand64();
      tick();
      do_read(RD_IMASK, 2'd0, 2);
      captures_on = 1'b1;
      repeat (NUM_OPS) begin
         r = rand64();
         if (r[0]) begin
            do_read(asi_rd_e'(r[1]), r[3:2], int'(r[5:4]));
         end else begin
            repeat (1 + r[7:6]) tick();
         end
      end
      repeat (4) tick();
      assert_fails = i_ifu_err_buffer.i_ifu_err_asserts.fails;
      $display("reads checked %0d, data errors %0d, handshake errors %0d, assertion failures %0d",
               reads_checked, data_errs, hs_errs, assert_fails);
      if (data_errs + hs_errs + assert_fails == 0) begin
         $display("NO ERRORS");
      end else begin
         $display("ERRORS FOUND");
      end
      $finish;
   end

   // watchdog
   always @(posedge rclk) begin
      cycle_cnt <= cycle_cnt + 1;
      if (cycle_cnt >= CYCLE_LIMIT) begin
         $display("timeout, run did not finish within %0d cycles", CYCLE_LIMIT);
         $display("ERRORS FOUND");
         $finish;
      end
   end

endmodule

// ==== sim/ifu_err_checker.sv ====
`timescale 1ns/1ps
// asi read checker, compares read words and imask with the model and watches the handshake
module ifu_err_checker (
   input  logic                            rclk,
   input  logic                            rst_n,
   input  logic                            asi_req,
   input  logic                            asi_ack,
   input  logic [ifu_err_pkg::ASI_W-1:0]   asi_rdata,
   input  logic [ifu_err_pkg::IMASK_W-1:0] imask,
   input  logic [ifu_err_pkg::ASI_W-1:0]   exp_rdata,
   input  logic [ifu_err_pkg::IMASK_W-1:0] exp_imask,
   output int unsigned                     reads_checked,
   output int unsigned                     data_errs,
   output int unsigned                     hs_errs
);
   // values sampled at the previous edge
   logic        ack_q = 1'b0;
   logic        req_q = 1'b0;
   // previous edge was in reset
   logic        rst_seen = 1'b0;
   // a request is in flight
   logic        busy = 1'b0;
   int unsigned edge_cnt = 0;
   int unsigned req_edge = 0;

   initial begin
      reads_checked = 0;
      data_errs     = 0;
      hs_errs       = 0;
   end

   // ----------------------------------------------------------
   // per-edge checks
   // ----------------------------------------------------------
   always @(posedge rclk) begin
      if (!rst_n) begin
         // ack cleared by the reset edge before
         if (rst_seen && asi_ack !== 1'b0) begin
            hs_errs++;
            $display("handshake fault at %0t: asi_ack high during reset", $time);
         end
         rst_seen = 1'b1;
         busy     = 1'b0;
         ack_q    = 1'b0;
         req_q    = 1'b0;
      end else begin
         edge_cnt++;
         // first edge out of reset
         if (rst_seen && asi_rdata !== '0) begin
            data_errs++;
            $display("FAILED %0t: asi_rdata %h after reset, expected zero", $time, asi_rdata);
         end
         rst_seen = 1'b0;
         if (imask !== exp_imask) begin
            data_errs++;
            $display("FAILED %0t: imask %h, expected %h", $time, imask, exp_imask);
         end
         // ack rise, sampled one edge late
         if (asi_ack && !ack_q) begin
            if (!busy) begin
               hs_errs++;
               $display("handshake fault at %0t: asi_ack rose with no request", $time);
            end else if (edge_cnt - req_edge != 3) begin
               hs_errs++;
               $display("handshake fault at %0t: asi_ack rose %0d edges after the request",
                        $time, edge_cnt - req_edge - 1);
            end
            reads_checked++;
            if (asi_rdata !== exp_rdata) begin
               data_errs++;
               $display("FAILED %0t: asi_rdata %h, expected %h", $time, asi_rdata, exp_rdata);
            end
         end
         if (busy && !asi_ack && !ack_q && edge_cnt - req_edge == 4) begin
            hs_errs++;
            $display("handshake fault at %0t: no asi_ack two edges after the request", $time);
         end
         if (ack_q && req_q && !asi_ack) begin
            hs_errs++;
            $display("handshake fault at %0t: asi_ack dropped while asi_req was held", $time);
         end
         if (ack_q && !req_q && asi_ack) begin
            hs_errs++;
            $display("handshake fault at %0t: asi_ack stayed high after asi_req dropped", $time);
         end
         // read done once ack is seen low
         if (ack_q && !asi_ack) busy = 1'b0;
         if (asi_req && !busy && !asi_ack) begin
            busy     = 1'b1;
            req_edge = edge_cnt;
         end
         ack_q = asi_ack;
         req_q = asi_req;
      end
   end

endmodule

// ==== sim/ifu_err_asserts.sv ====
`timescale 1ns/1ps
// asi handshake assertions, bound into the error buffer top
module ifu_err_asserts (
   input logic                          rclk,
   input logic                          rst_n,
   input logic                          asi_req,
   input logic                          asi_ack,
   input logic [ifu_err_pkg::ASI_W-1:0] asi_rdata
);
   // tally read back at the end of the run
   int unsigned fails = 0;

   // ack cleared by reset
   ack_low_in_reset: assert property (@(posedge rclk) !rst_n |=> !asi_ack)
      else begin
         $error("asi_ack high after a reset edge");
         fails++;
      end

   // rise only with a request up
   ack_rise_with_req: assert property (@(posedge rclk) disable iff (!rst_n)
      $rose(asi_ack) |-> $past(asi_req))
      else begin
         $error("asi_ack rose without asi_req");
         fails++;
      end

   ack_data_stable: assert property (@(posedge rclk) disable iff (!rst_n)
      asi_ack && $past(asi_ack) |-> $stable(asi_rdata))
      else begin
         $error("asi_rdata changed while asi_ack was high");
         fails++;
      end

   // fall only once req is low
   ack_fall_after_req: assert property (@(posedge rclk) disable iff (!rst_n)
      $fell(asi_ack) |-> !$past(asi_req))
      else begin
         $error("asi_ack fell while asi_req was high");
         fails++;
      end

endmodule

bind ifu_err_buffer ifu_err_asserts i_ifu_err_asserts (
   .rclk      (rclk),
   .rst_n     (rst_n),
   .asi_req   (asi_req),
   .asi_ack   (asi_ack),
   .asi_rdata (asi_rdata)
);

// ==== hdl/ifu_err_buffer.sv ====
`timescale 1ns/1ps
// ifu error buffer top, per-thread error addresses and instruction mask with asi readback
module ifu_err_buffer #(
   parameter int NUM_THREADS = 4
) (
   input  logic                                             rclk,
   input  logic                                             rst_n,
   // error sources
   input  logic [7:0]                                       irf_reg,
   input  logic [7:0]                                       irf_synd,
   input  logic [5:0]                                       frf_reg,
   input  logic [13:0]                                      frf_synd,
   input  logic [5:0]                                       itlb_index,
   input  logic [ifu_err_pkg::EADDR_W-1:0]                  lsu_err_addr,
   input  logic [ifu_err_pkg::PC_W-1:0]                     fetch_pc,
   input  logic [ifu_err_pkg::PA_W-ifu_err_pkg::PA_LO_W-1:0] itlb_paddr,
   input  logic [ifu_err_pkg::ASI_W-1:0]                    asi_wdata,
   input  logic                                             imask_ld,
   input  ifu_err_pkg::err_src_e [NUM_THREADS-1:0]          capture_sel,
   // asi read port
   input  logic                                             asi_req,
   input  ifu_err_pkg::asi_rd_e                             asi_rd_sel,
   input  logic [$clog2(NUM_THREADS)-1:0]                   asi_rd_thread,
   output logic                                             asi_ack,
   output logic [ifu_err_pkg::ASI_W-1:0]                    asi_rdata,
   output logic [ifu_err_pkg::IMASK_W-1:0]                  imask
);
   import ifu_err_pkg::*;

   // candidate words
   logic [EADDR_W-1:0] irf_word;
   logic [EADDR_W-1:0] frf_word;
   logic [EADDR_W-1:0] itlb_word;
   logic [EADDR_W-1:0] lsu_word;
   logic [EADDR_W-1:0] pc_word;
   logic [EADDR_W-1:0] paddr_word;
   logic [EADDR_W-1:0] wr_word;
   // read path
   logic [EADDR_W-1:0] rd_addr;
   logic               rd_load;

   // ----------------------------------------------------------
   // capture side
   // ----------------------------------------------------------
   err_source_stage i_err_source_stage (
      .rclk        (rclk),
      .rst_n       (rst_n),
      .irf_reg     (irf_reg),
      .irf_synd    (irf_synd),
      .frf_reg     (frf_reg),
      .frf_synd    (frf_synd),
      .itlb_index  (itlb_index),
      .lsu_err_addr(lsu_err_addr),
      .fetch_pc    (fetch_pc),
      .itlb_paddr  (itlb_paddr),
      .asi_wdata   (asi_wdata),
      .irf_word    (irf_word),
      .frf_word    (frf_word),
      .itlb_word   (itlb_word),
      .lsu_word    (lsu_word),
      .pc_word     (pc_word),
      .paddr_word  (paddr_word),
      .wr_word     (wr_word)
   );

   err_addr_file #(
      .NUM_THREADS (NUM_THREADS)
   ) i_err_addr_file (
      .rclk        (rclk),
      .rst_n       (rst_n),
      .capture_sel (capture_sel),
      .irf_word    (irf_word),
      .frf_word    (frf_word),
      .itlb_word   (itlb_word),
      .lsu_word    (lsu_word),
      .pc_word     (pc_word),
      .paddr_word  (paddr_word),
      .wr_word     (wr_word),
      .rd_thread   (asi_rd_thread),
      .rd_addr     (rd_addr)
   );

   // ----------------------------------------------------------
   // asi read side
   // ----------------------------------------------------------
   asi_read_ctl i_asi_read_ctl (
      .rclk    (rclk),
      .rst_n   (rst_n),
      .asi_req (asi_req),
      .asi_ack (asi_ack),
      .rd_load (rd_load)
   );

   asi_read_data i_asi_read_data (
      .rclk       (rclk),
      .rst_n      (rst_n),
      .imask_ld   (imask_ld),
      .asi_wdata  (asi_wdata),
      .asi_rd_sel (asi_rd_sel),
      .rd_addr    (rd_addr),
      .rd_load    (rd_load),
      .asi_rdata  (asi_rdata),
      .imask      (imask)
   );

endmodule

// ==== hdl/asi_read_data.sv ====
`timescale 1ns/1ps
// asi read data path, instruction mask register, read format mux and read register
module asi_read_data (
   input  logic                            rclk,
   input  logic                            rst_n,
   input  logic                            imask_ld,
   input  logic [ifu_err_pkg::ASI_W-1:0]   asi_wdata,
   input  ifu_err_pkg::asi_rd_e            asi_rd_sel,
   input  logic [ifu_err_pkg::EADDR_W-1:0] rd_addr,
   input  logic                            rd_load,
   output logic [ifu_err_pkg::ASI_W-1:0]   asi_rdata,
   output logic [ifu_err_pkg::IMASK_W-1:0] imask
);
   import ifu_err_pkg::*;

   // formatted read word before the register
   logic [ASI_W-1:0] rdata_nxt;

   // ----------------------------------------------------------
   // instruction mask
   // ----------------------------------------------------------
   always_ff @(posedge rclk) begin
      if (!rst_n) begin
         imask <= '0;
      end else if (imask_ld) begin
         // low 39 bits of the store word
         imask <= asi_wdata[IMASK_W-1:0];
      end
   end

   // ----------------------------------------------------------
   // read format mux
   // ----------------------------------------------------------
   always_comb begin
      case (asi_rd_sel)
         // error address back in bits 47:4
         RD_ERR_ADDR: rdata_nxt = {{RD_ERR_PAD_W{1'b0}}, rd_addr, {EADDR_LSB{1'b0}}};
         RD_IMASK:    rdata_nxt = {{RD_IMASK_PAD_W{1'b0}}, imask};
         default:     rdata_nxt = '0;
      endcase
   end

   // read register, held while ack is up
   always_ff @(posedge rclk) begin
      if (!rst_n) begin
         asi_rdata <= '0;
      end else if (rd_load) begin
         asi_rdata <= rdata_nxt;
      end
   end

endmodule

// ==== hdl/asi_read_ctl.sv ====
`timescale 1ns/1ps
// asi read control, four-phase req/ack FSM that sequences the read register
module asi_read_ctl (
   input  logic rclk,
   input  logic rst_n,
   input  logic asi_req,
   output logic asi_ack,
   output logic rd_load
);

   typedef enum logic [1:0] {
      IDLE = 2'd0,
      LOAD = 2'd1,
      ACK  = 2'd2
   } rd_state_e;

   rd_state_e state_q;
   rd_state_e state_nxt;

   // ----------------------------------------------------------
   // next state
   // ----------------------------------------------------------
   always_comb begin
      state_nxt = state_q;
      case (state_q)
         // wait for a request
         IDLE: if (asi_req) state_nxt = LOAD;
         // read register loads this cycle
         LOAD: state_nxt = ACK;
         // stay while the requester holds req
         ACK:  if (!asi_req) state_nxt = IDLE;
         default: state_nxt = IDLE;
      endcase
   end

   always_ff @(posedge rclk) begin
      if (!rst_n) begin
         state_q <= IDLE;
         asi_ack <= 1'b0;
      end else begin
         state_q <= state_nxt;
         // ack one edge after the data lands
         // drops on the edge that sees req low
         asi_ack <= (state_q == ACK) && asi_req;
      end
   end

   // one-cycle load strobe
   assign rd_load = (state_q == LOAD);

endmodule

// ==== hdl/err_addr_file.sv ====
`timescale 1ns/1ps
// error address file, one capture register per thread plus the asi read mux
module err_addr_file #(
   parameter int NUM_THREADS = 4
) (
   input  logic                                        rclk,
   input  logic                                        rst_n,
   input  ifu_err_pkg::err_src_e [NUM_THREADS-1:0]     capture_sel,
   input  logic [ifu_err_pkg::EADDR_W-1:0]             irf_word,
   input  logic [ifu_err_pkg::EADDR_W-1:0]             frf_word,
   input  logic [ifu_err_pkg::EADDR_W-1:0]             itlb_word,
   input  logic [ifu_err_pkg::EADDR_W-1:0]             lsu_word,
   input  logic [ifu_err_pkg::EADDR_W-1:0]             pc_word,
   input  logic [ifu_err_pkg::EADDR_W-1:0]             paddr_word,
   input  logic [ifu_err_pkg::EADDR_W-1:0]             wr_word,
   input  logic [$clog2(NUM_THREADS)-1:0]              rd_thread,
   output logic [ifu_err_pkg::EADDR_W-1:0]             rd_addr
);
   import ifu_err_pkg::*;

   // per-thread error address, bits 47:4
   logic [EADDR_W-1:0] err_q [NUM_THREADS];

   // ----------------------------------------------------------
   // per-thread source mux and register
   // ----------------------------------------------------------
   for (genvar t = 0; t < NUM_THREADS; t++) begin : g_thr
      logic [EADDR_W-1:0] err_nxt;

      // hold unless a source is picked
      always_comb begin
         case (capture_sel[t])
            SRC_IRF:    err_nxt = irf_word;
            SRC_ITLB:   err_nxt = itlb_word;
            SRC_FRF:    err_nxt = frf_word;
            SRC_LSU:    err_nxt = lsu_word;
            SRC_PC:     err_nxt = pc_word;
            SRC_PADDR:  err_nxt = paddr_word;
            SRC_ASI_WR: err_nxt = wr_word;
            default:    err_nxt = err_q[t];
         endcase
      end

      always_ff @(posedge rclk) begin
         if (!rst_n) begin
            err_q[t] <= '0;
         end else begin
            err_q[t] <= err_nxt;
         end
      end
   end

   // ----------------------------------------------------------
   // asi read side
   // ----------------------------------------------------------
   // thread pick for the read register
   assign rd_addr = err_q[rd_thread];

endmodule

// ==== hdl/err_source_stage.sv ====
`timescale 1ns/1ps
// error source staging, registers the error sources and builds the candidate words
module err_source_stage (
   input  logic                                             rclk,
   input  logic                                             rst_n,
   input  logic [7:0]                                       irf_reg,
   input  logic [7:0]                                       irf_synd,
   input  logic [5:0]                                       frf_reg,
   input  logic [13:0]                                      frf_synd,
   input  logic [5:0]                                       itlb_index,
   input  logic [ifu_err_pkg::EADDR_W-1:0]                  lsu_err_addr,
   input  logic [ifu_err_pkg::PC_W-1:0]                     fetch_pc,
   input  logic [ifu_err_pkg::PA_W-ifu_err_pkg::PA_LO_W-1:0] itlb_paddr,
   input  logic [ifu_err_pkg::ASI_W-1:0]                    asi_wdata,
   output logic [ifu_err_pkg::EADDR_W-1:0]                  irf_word,
   output logic [ifu_err_pkg::EADDR_W-1:0]                  frf_word,
   output logic [ifu_err_pkg::EADDR_W-1:0]                  itlb_word,
   output logic [ifu_err_pkg::EADDR_W-1:0]                  lsu_word,
   output logic [ifu_err_pkg::EADDR_W-1:0]                  pc_word,
   output logic [ifu_err_pkg::EADDR_W-1:0]                  paddr_word,
   output logic [ifu_err_pkg::EADDR_W-1:0]                  wr_word
);
   import ifu_err_pkg::*;

   // staged irf record
   logic [7:0]              irf_reg_q;
   logic [7:0]              irf_synd_q;
   logic                    irf_bit4;
   logic [5:0]              itlb_index_q;
   logic [EADDR_W-1:0]      lsu_q;
   // pc pipe, s1 then d1
   logic [PC_W-1:EADDR_LSB] pc_s1;
   logic [PC_W-1:EADDR_LSB] pc_d1;
   // itlb page bits joined with the s1 page offset
   logic [PA_W-1:0]         paddr_d1;

   // ----------------------------------------------------------
   // staging registers
   // ----------------------------------------------------------
   always_ff @(posedge rclk) begin
      if (!rst_n) begin
         irf_reg_q    <= '0;
         irf_synd_q   <= '0;
         itlb_index_q <= '0;
         lsu_q        <= '0;
         pc_s1        <= '0;
         pc_d1        <= '0;
         paddr_d1     <= '0;
      end else begin
         irf_reg_q    <= irf_reg;
         irf_synd_q   <= irf_synd;
         itlb_index_q <= itlb_index;
         lsu_q        <= lsu_err_addr;
         pc_s1        <= fetch_pc[PC_W-1:EADDR_LSB];
         // second pc stage
         pc_d1        <= pc_s1;
         // page offset comes from the older pc
         paddr_d1     <= {itlb_paddr, pc_s1[EADDR_LSB+PA_LO_W-1:EADDR_LSB]};
      end
   end

   // register number bit 4 fixup
   assign irf_bit4 = irf_reg_q[4] ^ (irf_reg_q[5] & irf_reg_q[3]);

   // ----------------------------------------------------------
   // word formats
   // ----------------------------------------------------------
   assign irf_word   = {24'b0, irf_synd_q, 4'b0, irf_reg_q[7:5], irf_bit4, irf_reg_q[3:0]};
   // frf record is already at w2, no staging
   assign frf_word   = {17'b0, frf_synd[13:7], 1'b0, frf_synd[6:0], 6'b0, frf_reg};
   assign itlb_word  = {38'b0, itlb_index_q};
   assign lsu_word   = lsu_q;
   assign pc_word    = pc_d1;
   assign paddr_word = {{(EADDR_W - PA_W){1'b0}}, paddr_d1};
   // asi store data, address bits 47:4
   assign wr_word    = asi_wdata[EADDR_W+EADDR_LSB-1:EADDR_LSB];

endmodule

// ==== hdl/ifu_err_pkg.sv ====
// ifu error buffer package, shared widths, capture and read-select encodings
package ifu_err_pkg;

   // ----------------------------------------------------------
   // widths
   // ----------------------------------------------------------

   // error address holds bits 47:4
   localparam int EADDR_W   = 44;
   // full fetch pc
   localparam int PC_W      = 48;
   // physical address bits 39:4
   localparam int PA_W      = 36;
   // asi load/store word
   localparam int ASI_W     = 64;
   // instruction mask
   localparam int IMASK_W   = 39;

   // ----------------------------------------------------------
   // format constants
   // ----------------------------------------------------------

   // lowest address bit kept in an error address
   localparam int EADDR_LSB      = 4;
   // page offset bits 9:4 taken from the pc, rest from itlb
   localparam int PA_LO_W        = 6;
   // zero fill above the error address in the asi word
   localparam int RD_ERR_PAD_W   = ASI_W - EADDR_W - EADDR_LSB;
   // zero fill above the mask in the asi word
   localparam int RD_IMASK_PAD_W = ASI_W - IMASK_W;

   // ----------------------------------------------------------
   // encodings
   // ----------------------------------------------------------

   // per-thread capture source, hold is the idle value
   typedef enum logic [2:0] {
      SRC_HOLD   = 3'd0,
      SRC_IRF    = 3'd1,
      SRC_ITLB   = 3'd2,
      SRC_FRF    = 3'd3,
      SRC_LSU    = 3'd4,
      SRC_PC     = 3'd5,
      SRC_PADDR  = 3'd6,
      SRC_ASI_WR = 3'd7
   } err_src_e;

   // asi read target
   typedef enum logic {
      RD_ERR_ADDR = 1'b0,
      RD_IMASK    = 1'b1
   } asi_rd_e;

endpackage
